/* src/afu_pkg.sv */
`default_nettype none

package afu_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	// Command address and compute-unit id
	localparam int ADDR_W = 64;
	localparam int CU_ID_W = 8;

	// Link tag field and the local tag table
	localparam int TAG_W = 8;
	localparam int NUM_TAGS = 8;
	localparam int TAG_IDX_W = $clog2(NUM_TAGS);

	// Link credits held after reset
	localparam int MAX_CREDITS = 4;
	localparam int CREDIT_W = 4;

	// Per-class command queue
	localparam int CMD_FIFO_DEPTH = 16;

	// Sticky error status with one bit per error class
	localparam int ERR_W = 4;
	localparam int ERR_AERROR = 0;
	localparam int ERR_DERROR = 1;
	localparam int ERR_FAILED = 2;
	localparam int ERR_OTHER = 3;

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	// Command class kept per tag
	typedef enum logic {
		CLASS_READ = 1'b0,
		CLASS_WRITE = 1'b1
	} cmd_class_t;

	// Link command opcodes
	typedef enum logic [12:0] {
		OP_READ_CL_NA = 13'h0A00,
		OP_WRITE_NA = 13'h0D00
	} psl_opcode_t;

	// Link response codes where unlisted codes count as other errors
	typedef enum logic [7:0] {
		RSP_DONE = 8'd0,
		RSP_AERROR = 8'd1,
		RSP_DERROR = 8'd3,
		RSP_FAILED = 8'd5,
		RSP_PAGED = 8'd10
	} rsp_code_t;

endpackage

`default_nettype wire

/* src/cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo #(
	parameter int WIDTH = 72,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage array
	logic [WIDTH-1:0] mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Qualified requests where a push while full is dropped
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head shown without a register stage
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Wrap at DEPTH even when not a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keeps the count
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/command_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module command_arbiter (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       read_cmd_valid,
	input  logic [afu_pkg::ADDR_W-1:0]  read_cmd_address,
	input  logic [afu_pkg::CU_ID_W-1:0] read_cmd_cu_id,
	input  logic                       write_cmd_valid,
	input  logic [afu_pkg::ADDR_W-1:0]  write_cmd_address,
	input  logic [afu_pkg::CU_ID_W-1:0] write_cmd_cu_id,
	input  logic                       issue_grant,
	output logic                       arb_valid,
	output afu_pkg::cmd_class_t        arb_class,
	output logic [afu_pkg::ADDR_W-1:0]  arb_address,
	output logic [afu_pkg::CU_ID_W-1:0] arb_cu_id,
	output logic                       read_fifo_full,
	output logic                       write_fifo_full
);

	import afu_pkg::*;

	// One FIFO line holds address above cu_id
	localparam int LINE_W = ADDR_W + CU_ID_W;

	logic [LINE_W-1:0] read_line;
	logic [LINE_W-1:0] write_line;
	logic read_empty;
	logic write_empty;
	logic read_pop;
	logic write_pop;
	logic [LINE_W-1:0] sel_line;

	//////////////////////////////////////////////////
	// Per-class command queues
	//////////////////////////////////////////////////

	cmd_fifo #(
		.WIDTH(LINE_W),
		.DEPTH(CMD_FIFO_DEPTH)
	) read_fifo_i (
		.clock   (clock),
		.rst_n   (rst_n),
		.push    (read_cmd_valid),
		.data_in ({read_cmd_address, read_cmd_cu_id}),
		.pop     (read_pop),
		.data_out(read_line),
		.empty   (read_empty),
		.full    (read_fifo_full)
	);

	cmd_fifo #(
		.WIDTH(LINE_W),
		.DEPTH(CMD_FIFO_DEPTH)
	) write_fifo_i (
		.clock   (clock),
		.rst_n   (rst_n),
		.push    (write_cmd_valid),
		.data_in ({write_cmd_address, write_cmd_cu_id}),
		.pop     (write_pop),
		.data_out(write_line),
		.empty   (write_empty),
		.full    (write_fifo_full)
	);

	//////////////////////////////////////////////////
	// Fixed priority with writes first
	//////////////////////////////////////////////////

	assign arb_valid = !write_empty || !read_empty;
	assign arb_class = write_empty ? CLASS_READ : CLASS_WRITE;
	assign sel_line = write_empty ? read_line : write_line;

	// Unpack the winning line
	assign arb_address = sel_line[LINE_W-1:CU_ID_W];
	assign arb_cu_id = sel_line[CU_ID_W-1:0];

	// Grant pops only the queue that won
	assign write_pop = issue_grant && !write_empty;
	assign read_pop = issue_grant && write_empty;

endmodule

`default_nettype wire

/* src/response_control.sv */
`timescale 1ns/100ps
`default_nettype none

module response_control (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        response_valid,
	input  logic [afu_pkg::TAG_W-1:0]    response_tag,
	input  afu_pkg::rsp_code_t           response_code,
	input  logic [afu_pkg::CREDIT_W-1:0] response_credits,
	output logic                        rsp_valid,
	output logic [afu_pkg::TAG_W-1:0]    rsp_tag,
	output logic                        rsp_error,
	output logic [afu_pkg::CREDIT_W-1:0] rsp_credits,
	output logic [afu_pkg::ERR_W-1:0]    error_status
);

	import afu_pkg::*;

	// Latched response code
	rsp_code_t rsp_code;

	// One-hot error class of the latched code
	logic [ERR_W-1:0] err_bits;

	//////////////////////////////////////////////////
	// Link response latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= response_valid;
		end
	end

	// Payload taken every cycle and qualified by rsp_valid
	always_ff @(posedge clock) begin
		rsp_tag <= response_tag;
		rsp_code <= response_code;
		rsp_credits <= response_credits;
	end

	//////////////////////////////////////////////////
	// Code decode
	//////////////////////////////////////////////////

	always_comb begin
		err_bits = '0;
		case (rsp_code)
			RSP_DONE: err_bits = '0;
			RSP_AERROR: err_bits[ERR_AERROR] = 1'b1;
			RSP_DERROR: err_bits[ERR_DERROR] = 1'b1;
			RSP_FAILED: err_bits[ERR_FAILED] = 1'b1;
			// Paged and unknown codes
			default: err_bits[ERR_OTHER] = 1'b1;
		endcase
	end

	// Anything but done is an error
	assign rsp_error = (rsp_code != RSP_DONE);

	// Sticky status cleared only by reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			error_status <= '0;
		end else if (rsp_valid) begin
			error_status <= error_status | err_bits;
		end
	end

endmodule

`default_nettype wire

/* src/tag_control.sv */
`timescale 1ns/100ps
`default_nettype none

module tag_control (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        enabled,
	input  logic                        arb_valid,
	input  afu_pkg::cmd_class_t          arb_class,
	input  logic [afu_pkg::ADDR_W-1:0]   arb_address,
	input  logic [afu_pkg::CU_ID_W-1:0]  arb_cu_id,
	input  logic                        rsp_valid,
	input  logic [afu_pkg::TAG_W-1:0]    rsp_tag,
	input  logic                        rsp_error,
	input  logic [afu_pkg::CREDIT_W-1:0] rsp_credits,
	output logic                        issue_grant,
	output logic                        command_valid,
	output afu_pkg::psl_opcode_t         command_opcode,
	output logic [afu_pkg::ADDR_W-1:0]   command_address,
	output logic [afu_pkg::TAG_W-1:0]    command_tag,
	output logic                        read_response_valid,
	output logic                        write_response_valid,
	output logic [afu_pkg::CU_ID_W-1:0]  response_cu_id,
	output logic                        response_error
);

	import afu_pkg::*;

	logic [CREDIT_W-1:0] credits;
	logic [CREDIT_W:0] credit_sum;
	logic [CREDIT_W-1:0] credit_return;

	// Tag table with a busy bit, class and cu_id per entry
	logic [NUM_TAGS-1:0] busy;
	cmd_class_t tag_class [NUM_TAGS];
	logic [CU_ID_W-1:0] tag_cu_id [NUM_TAGS];

	logic tag_free;
	logic [TAG_IDX_W-1:0] free_idx;
	logic [TAG_IDX_W-1:0] rsp_idx;
	logic rsp_hit;

	//////////////////////////////////////////////////
	// Tag allocation and grant
	//////////////////////////////////////////////////

	// Scan from the top so the lowest free entry wins
	always_comb begin
		free_idx = '0;
		tag_free = 1'b0;
		for (int i = NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = TAG_IDX_W'(i);
				tag_free = 1'b1;
			end
		end
	end

	assign issue_grant = arb_valid && enabled && (credits != '0) && tag_free;

	// Responses to idle or out-of-range tags are dropped
	assign rsp_idx = rsp_tag[TAG_IDX_W-1:0];
	assign rsp_hit = rsp_valid && (rsp_tag < TAG_W'(NUM_TAGS)) && busy[rsp_idx];

	//////////////////////////////////////////////////
	// Credit counter
	//////////////////////////////////////////////////

	assign credit_return = rsp_hit ? rsp_credits : '0;
	// No underflow since a grant needs a credit
	assign credit_sum = {1'b0, credits} + {1'b0, credit_return}
		- {{CREDIT_W{1'b0}}, issue_grant};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(MAX_CREDITS);
			busy <= '0;
			command_valid <= 1'b0;
			read_response_valid <= 1'b0;
			write_response_valid <= 1'b0;
		end else begin
			// Saturate at the link allowance
			if (credit_sum > (CREDIT_W + 1)'(MAX_CREDITS)) begin
				credits <= CREDIT_W'(MAX_CREDITS);
			end else begin
				credits <= credit_sum[CREDIT_W-1:0];
			end
			// Release and claim never hit the same entry
			if (rsp_hit) begin
				busy[rsp_idx] <= 1'b0;
			end
			if (issue_grant) begin
				busy[free_idx] <= 1'b1;
			end
			command_valid <= issue_grant;
			// Route by the class stored at issue
			read_response_valid <= rsp_hit && (tag_class[rsp_idx] == CLASS_READ);
			write_response_valid <= rsp_hit && (tag_class[rsp_idx] == CLASS_WRITE);
		end
	end

	//////////////////////////////////////////////////
	// Command and response payload
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (issue_grant) begin
			tag_class[free_idx] <= arb_class;
			tag_cu_id[free_idx] <= arb_cu_id;
			command_opcode <= (arb_class == CLASS_WRITE) ? OP_WRITE_NA : OP_READ_CL_NA;
			command_address <= arb_address;
			command_tag <= TAG_W'(free_idx);
		end
		if (rsp_hit) begin
			response_cu_id <= tag_cu_id[rsp_idx];
			response_error <= rsp_error;
		end
	end

endmodule

`default_nettype wire

/* src/afu_control.sv */
`timescale 1ns/100ps
`default_nettype none

module afu_control (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        enabled,
	// Compute-unit command intake
	input  logic                        read_cmd_valid,
	input  logic [afu_pkg::ADDR_W-1:0]   read_cmd_address,
	input  logic [afu_pkg::CU_ID_W-1:0]  read_cmd_cu_id,
	input  logic                        write_cmd_valid,
	input  logic [afu_pkg::ADDR_W-1:0]   write_cmd_address,
	input  logic [afu_pkg::CU_ID_W-1:0]  write_cmd_cu_id,
	output logic                        read_fifo_full,
	output logic                        write_fifo_full,
	// Link command side
	output logic                        command_valid,
	output afu_pkg::psl_opcode_t         command_opcode,
	output logic [afu_pkg::ADDR_W-1:0]   command_address,
	output logic [afu_pkg::TAG_W-1:0]    command_tag,
	// Link response side
	input  logic                        response_valid,
	input  logic [afu_pkg::TAG_W-1:0]    response_tag,
	input  afu_pkg::rsp_code_t           response_code,
	input  logic [afu_pkg::CREDIT_W-1:0] response_credits,
	// Responses back to the compute unit
	output logic                        read_response_valid,
	output logic                        write_response_valid,
	output logic [afu_pkg::CU_ID_W-1:0]  response_cu_id,
	output logic                        response_error,
	output logic [afu_pkg::ERR_W-1:0]    error_status
);

	import afu_pkg::*;

	// Arbiter to issue
	logic arb_valid;
	cmd_class_t arb_class;
	logic [ADDR_W-1:0] arb_address;
	logic [CU_ID_W-1:0] arb_cu_id;
	logic issue_grant;

	// Latched response to tag lookup
	logic rsp_valid;
	logic [TAG_W-1:0] rsp_tag;
	logic rsp_error;
	logic [CREDIT_W-1:0] rsp_credits;

	//////////////////////////////////////////////////
	// Command queues and selection
	//////////////////////////////////////////////////

	command_arbiter command_arbiter_i (
		.clock            (clock),
		.rst_n            (rst_n),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_address (read_cmd_address),
		.read_cmd_cu_id   (read_cmd_cu_id),
		.write_cmd_valid  (write_cmd_valid),
		.write_cmd_address(write_cmd_address),
		.write_cmd_cu_id  (write_cmd_cu_id),
		.issue_grant      (issue_grant),
		.arb_valid        (arb_valid),
		.arb_class        (arb_class),
		.arb_address      (arb_address),
		.arb_cu_id        (arb_cu_id),
		.read_fifo_full   (read_fifo_full),
		.write_fifo_full  (write_fifo_full)
	);

	//////////////////////////////////////////////////
	// Response latch and decode
	//////////////////////////////////////////////////

	response_control response_control_i (
		.clock           (clock),
		.rst_n           (rst_n),
		.response_valid  (response_valid),
		.response_tag    (response_tag),
		.response_code   (response_code),
		.response_credits(response_credits),
		.rsp_valid       (rsp_valid),
		.rsp_tag         (rsp_tag),
		.rsp_error       (rsp_error),
		.rsp_credits     (rsp_credits),
		.error_status    (error_status)
	);

	//////////////////////////////////////////////////
	// Credits, tags, issue and routing
	//////////////////////////////////////////////////

	tag_control tag_control_i (
		.clock               (clock),
		.rst_n               (rst_n),
		.enabled             (enabled),
		.arb_valid           (arb_valid),
		.arb_class           (arb_class),
		.arb_address         (arb_address),
		.arb_cu_id           (arb_cu_id),
		.rsp_valid           (rsp_valid),
		.rsp_tag             (rsp_tag),
		.rsp_error           (rsp_error),
		.rsp_credits         (rsp_credits),
		.issue_grant         (issue_grant),
		.command_valid       (command_valid),
		.command_opcode      (command_opcode),
		.command_address     (command_address),
		.command_tag         (command_tag),
		.read_response_valid (read_response_valid),
		.write_response_valid(write_response_valid),
		.response_cu_id      (response_cu_id),
		.response_error      (response_error)
	);

endmodule

`default_nettype wire

/* tb/afu_control_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module afu_control_tb;

	import afu_pkg::*;

	localparam int CLOCK_PERIOD = 10;
	localparam int PHASES = 5;
	localparam int TIMEOUT_CYCLES = PHASES * 200;

	// Pushed command with the cycle count at the push as stamp
	typedef struct packed {
		int stamp;
		logic [ADDR_W-1:0] address;
		logic [CU_ID_W-1:0] cu_id;
	} cmd_entry_t;

	// Response expected on a strobe at cycle due
	typedef struct packed {
		int due;
		int tag;
		logic is_write;
		logic [CU_ID_W-1:0] cu_id;
		logic error;
		logic [ERR_W-1:0] err_bits;
		logic [CREDIT_W-1:0] credits;
	} rsp_entry_t;

	logic clock;
	logic rst_n;
	logic enabled;
	logic read_cmd_valid;
	logic [ADDR_W-1:0] read_cmd_address;
	logic [CU_ID_W-1:0] read_cmd_cu_id;
	logic write_cmd_valid;
	logic [ADDR_W-1:0] write_cmd_address;
	logic [CU_ID_W-1:0] write_cmd_cu_id;
	logic read_fifo_full;
	logic write_fifo_full;
	logic command_valid;
	psl_opcode_t command_opcode;
	logic [ADDR_W-1:0] command_address;
	logic [TAG_W-1:0] command_tag;
	logic response_valid;
	logic [TAG_W-1:0] response_tag;
	rsp_code_t response_code;
	logic [CREDIT_W-1:0] response_credits;
	logic read_response_valid;
	logic write_response_valid;
	logic [CU_ID_W-1:0] response_cu_id;
	logic response_error;
	logic [ERR_W-1:0] error_status;

	//////////////////////////////////////////////////
	// Reference model state
	//////////////////////////////////////////////////

	cmd_entry_t read_q [$];
	cmd_entry_t write_q [$];
	rsp_entry_t rsp_q [$];
	logic out_busy [NUM_TAGS];
	logic out_is_write [NUM_TAGS];
	logic [CU_ID_W-1:0] out_cu [NUM_TAGS];
	logic rsp_pending [NUM_TAGS];
	logic [ERR_W-1:0] model_err;
	int model_credits;
	int issue_count;
	int rsp_sent;
	int cycle = 0;
	logic enabled_at_edge;
	logic [15:0] lfsr_state;

	afu_control dut_i (.*);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Edge count and the enable seen by the grant logic
	always @(posedge clock) begin
		cycle <= cycle + 1;
		enabled_at_edge <= enabled;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("CHECK FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[62:0], lfsr_state[0]};
		end
	endtask

	function automatic rsp_code_t code_for(input int k);
		case (k % 5)
			0: return RSP_DONE;
			1: return RSP_AERROR;
			2: return RSP_DERROR;
			3: return RSP_FAILED;
			default: return RSP_PAGED;
		endcase
	endfunction

	// Error class of a link code
	function automatic logic [ERR_W-1:0] err_bits_of(input rsp_code_t code);
		logic [ERR_W-1:0] bits;
		bits = '0;
		case (code)
			RSP_DONE: bits = '0;
			RSP_AERROR: bits[ERR_AERROR] = 1'b1;
			RSP_DERROR: bits[ERR_DERROR] = 1'b1;
			RSP_FAILED: bits[ERR_FAILED] = 1'b1;
			default: bits[ERR_OTHER] = 1'b1;
		endcase
		return bits;
	endfunction

	// Lowest outstanding tag with no response on its way or -1 if none
	function automatic int pick_tag();
		for (int i = 0; i < NUM_TAGS; i++) begin
			if (out_busy[i] && !rsp_pending[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic push_cmd(input logic is_write);
		cmd_entry_t entry;
		logic [63:0] bits;
		take_bits(ADDR_W, bits);
		entry.address = bits;
		take_bits(CU_ID_W, bits);
		entry.cu_id = bits[CU_ID_W-1:0];
		entry.stamp = cycle;
		if (is_write) begin
			write_cmd_valid = 1'b1;
			write_cmd_address = entry.address;
			write_cmd_cu_id = entry.cu_id;
			write_q.push_back(entry);
		end else begin
			read_cmd_valid = 1'b1;
			read_cmd_address = entry.address;
			read_cmd_cu_id = entry.cu_id;
			read_q.push_back(entry);
		end
		@(negedge clock);
		read_cmd_valid = 1'b0;
		write_cmd_valid = 1'b0;
	endtask

	// Strobe due two edges after the link response
	task automatic send_response(input int idx, input rsp_code_t code,
		input logic [CREDIT_W-1:0] credits);
		rsp_entry_t entry;
		entry.due = cycle + 2;
		entry.tag = idx;
		entry.is_write = out_is_write[idx];
		entry.cu_id = out_cu[idx];
		entry.error = (code != RSP_DONE);
		entry.err_bits = err_bits_of(code);
		entry.credits = credits;
		rsp_pending[idx] = 1'b1;
		rsp_q.push_back(entry);
		rsp_sent++;
		response_valid = 1'b1;
		response_tag = TAG_W'(idx);
		response_code = code;
		response_credits = credits;
		@(negedge clock);
		response_valid = 1'b0;
	endtask

	task automatic respond_one(input rsp_code_t code, input logic [CREDIT_W-1:0] credits);
		int idx;
		idx = pick_tag();
		while (idx < 0) begin
			@(negedge clock);
			idx = pick_tag();
		end
		send_response(idx, code, credits);
	endtask

	task automatic wait_issues(input int n);
		while (issue_count < n) begin
			@(negedge clock);
		end
	endtask

	// Answer every outstanding command and wait for the last strobe
	task automatic drain_all(input logic [CREDIT_W-1:0] credits);
		int k;
		k = 0;
		while (read_q.size() + write_q.size() != 0 || rsp_sent != issue_count) begin
			respond_one(code_for(k), credits);
			k++;
		end
		while (rsp_q.size() != 0) begin
			@(negedge clock);
		end
	endtask

	//////////////////////////////////////////////////
	// Checks at the falling edge where outputs are settled
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		cmd_entry_t head;
		rsp_entry_t due_rsp;
		int t;
		if (rst_n) begin
			// Issue first since the grant saw the table before this edge
			if (command_valid) begin
				assert (enabled_at_edge) else report_mismatch("command_valid", 1, 0);
				assert (model_credits > 0) else report_mismatch("command_valid", 1, 0);
				if (command_opcode == OP_WRITE_NA) begin
					assert (write_q.size() > 0) else
						report_mismatch("command_opcode", command_opcode, OP_READ_CL_NA);
					head = write_q.pop_front();
				end else begin
					assert (command_opcode == OP_READ_CL_NA) else
						report_mismatch("command_opcode", command_opcode, OP_READ_CL_NA);
					assert (read_q.size() > 0) else
						report_mismatch("command_opcode", command_opcode, OP_WRITE_NA);
					// A write already in its FIFO would have won
					assert (write_q.size() == 0 || write_q[0].stamp > cycle - 2) else
						report_mismatch("command_opcode", command_opcode, OP_WRITE_NA);
					head = read_q.pop_front();
				end
				assert (command_address == head.address) else
					report_mismatch("command_address", command_address, head.address);
				t = int'(command_tag);
				assert (t < NUM_TAGS) else
					report_mismatch("command_tag", command_tag, NUM_TAGS - 1);
				assert (!out_busy[t]) else report_mismatch("command_tag busy", 1, 0);
				out_busy[t] = 1'b1;
				out_is_write[t] = (command_opcode == OP_WRITE_NA);
				out_cu[t] = head.cu_id;
				model_credits--;
				issue_count++;
			end
			// Response strobes
			if (rsp_q.size() > 0 && rsp_q[0].due == cycle) begin
				due_rsp = rsp_q.pop_front();
				assert (read_response_valid == !due_rsp.is_write) else
					report_mismatch("read_response_valid", read_response_valid,
						!due_rsp.is_write);
				assert (write_response_valid == due_rsp.is_write) else
					report_mismatch("write_response_valid", write_response_valid,
						due_rsp.is_write);
				assert (response_cu_id == due_rsp.cu_id) else
					report_mismatch("response_cu_id", response_cu_id, due_rsp.cu_id);
				assert (response_error == due_rsp.error) else
					report_mismatch("response_error", response_error, due_rsp.error);
				out_busy[due_rsp.tag] = 1'b0;
				rsp_pending[due_rsp.tag] = 1'b0;
				model_err = model_err | due_rsp.err_bits;
				model_credits = model_credits + int'(due_rsp.credits);
				if (model_credits > MAX_CREDITS) begin
					model_credits = MAX_CREDITS;
				end
			end else begin
				assert (!read_response_valid) else report_mismatch("read_response_valid", 1, 0);
				assert (!write_response_valid) else report_mismatch("write_response_valid", 1, 0);
			end
			assert (error_status == model_err) else
				report_mismatch("error_status", error_status, model_err);
			// Model holds at least what the FIFO holds
			assert (!read_fifo_full || read_q.size() >= CMD_FIFO_DEPTH) else
				report_mismatch("read_fifo_full", 1, 0);
			assert (!write_fifo_full || write_q.size() >= CMD_FIFO_DEPTH) else
				report_mismatch("write_fifo_full", 1, 0);
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [63:0] sel;
		int idx;
		clock = 1'b0;
		rst_n = 1'b0;
		enabled = 1'b0;
		read_cmd_valid = 1'b0;
		read_cmd_address = '0;
		read_cmd_cu_id = '0;
		write_cmd_valid = 1'b0;
		write_cmd_address = '0;
		write_cmd_cu_id = '0;
		response_valid = 1'b0;
		response_tag = '0;
		response_code = RSP_DONE;
		response_credits = '0;
		for (int i = 0; i < NUM_TAGS; i++) begin
			out_busy[i] = 1'b0;
			out_is_write[i] = 1'b0;
			out_cu[i] = '0;
			rsp_pending[i] = 1'b0;
		end
		model_err = '0;
		model_credits = MAX_CREDITS;
		issue_count = 0;
		rsp_sent = 0;
		lfsr_state = 16'd62;
		repeat (2) @(negedge clock);
		rst_n = 1'b1;

		// Queues fill while disabled and nothing issues
		for (int i = 0; i < CMD_FIFO_DEPTH; i++) begin
			push_cmd(1'b0);
		end
		assert (read_fifo_full) else report_mismatch("read_fifo_full", read_fifo_full, 1);
		push_cmd(1'b1);
		push_cmd(1'b1);
		repeat (5) @(negedge clock);

		// Writes first and then the credit limit
		enabled = 1'b1;
		wait_issues(MAX_CREDITS);
		repeat (10) @(negedge clock);
		assert (issue_count == MAX_CREDITS) else
			report_mismatch("issue_count", issue_count, MAX_CREDITS);
		respond_one(RSP_DONE, 1);
		wait_issues(MAX_CREDITS + 1);
		repeat (10) @(negedge clock);
		assert (issue_count == MAX_CREDITS + 1) else
			report_mismatch("issue_count", issue_count, MAX_CREDITS + 1);

		// One credit per response with every code in turn
		drain_all(1);

		// Mixed random traffic with one or two credits back
		for (int i = 0; i < 60; i++) begin
			take_bits(2, sel);
			idx = pick_tag();
			if (sel[1:0] == 2'd0 && read_q.size() < 12) begin
				push_cmd(1'b0);
			end else if (sel[1:0] == 2'd1 && write_q.size() < 12) begin
				push_cmd(1'b1);
			end else if (idx >= 0) begin
				take_bits(1, sel);
				send_response(idx, code_for(i), CREDIT_W'(1 + sel[0]));
			end else begin
				@(negedge clock);
			end
		end
		drain_all(2);
		repeat (5) @(negedge clock);
		assert (error_status == 4'hF) else
			report_mismatch("error_status", error_status, 4'hF);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
src/afu_pkg.sv
src/cmd_fifo.sv
src/command_arbiter.sv
src/response_control.sv
src/tag_control.sv
src/afu_control.sv
tb/afu_control_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module afu_control_tb -o afu_sim

status=0
./obj_dir/afu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation FAILED: no pass message, exit status $status"
	exit 1
fi
echo "Simulation PASSED"
